// ==== decode_macros.svh ====
// Decode pipeline sizing constants shared by the package and the RTL stages.
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// **************************************************
// Flow control
// **************************************************

`define QUEUE_DEPTH 4   // Opcode FIFO entries, also the upstream credits.
`define OUT_CREDITS 2   // Downstream credits after reset.

// **************************************************
// Step counter
// **************************************************

`define XPT_WIDTH 4     // Width of the XPT step number.

`endif

// ==== decodePkg.sv ====
// Decode pipeline types: opcode and step vectors, control word and stream beats.
`default_nettype none

`include "decode_macros.svh"

package decodePkg;

    typedef logic [7:0] opIndex_t;                  // ITABLE.
    typedef logic [`XPT_WIDTH-1:0] stepIndex_t;     // XPT.
    typedef logic [2:0] slotMask_t;                 // One-hot slot 0/1/2.

    // **************************************************
    // Control word, one per execution step
    // **************************************************

    typedef struct packed {
        slotMask_t readSlot;        // R0/R1/R2.
        slotMask_t writeSlot;       // W0/W1/W2.
        logic selectOld;
        logic selectAdt1;
        logic invertIn;
        logic writeL;
        logic writeH;
        logic writeIxHigh;
        logic writeIyHigh;
        logic writeIxLow;
        logic writeIyLow;
        logic decSp;
        logic selectAdSp;
        logic selectDtPcHigh;
        logic selectDtPcLow;
        logic writePcHigh;
        logic writePcLow;
        logic selectOldLow;
        logic nop;
        logic lastStep;             // Final step of the opcode.
    } controlWord_t;

    typedef struct packed {
        logic valid;
        opIndex_t opIndex;
    } opBeat_t;

    typedef struct packed {
        logic valid;
        opIndex_t opIndex;
        stepIndex_t step;
        controlWord_t control;
    } microOp_t;

    typedef enum logic {
        idle,
        stepping
    } seqState_t;

endpackage

`default_nettype wire

// ==== transferGroupDecoder.sv ====
// Transfer group decoder leaf for opcodes 000 0 1xx1, two steps: read slot then write slot.
`default_nettype none

module transferGroupDecoder (
    input  wire                          enable,
    input  wire  decodePkg::opIndex_t    opIndex,
    input  wire  decodePkg::stepIndex_t  step,
    output decodePkg::controlWord_t      control
);
    import decodePkg::*;

    logic [1:0] r;
    slotMask_t slotBit;

    assign r = opIndex[2:1];
    assign slotBit = slotMask_t'(3'b001 << r);  // Empty when r is 3.

    always_comb begin
        control = '0;
        if (enable) begin
            case (step)
                stepIndex_t'(0): begin
                    control.selectOld = 1'b1;
                    control.readSlot = slotBit;
                    control.invertIn = (r == 2'd3);
                end
                stepIndex_t'(1): begin
                    control.writeSlot = slotBit;
                    control.writeL = !r[0];
                    control.writeH = r[0];
                    control.writeIxHigh = (r == 2'd2);
                    control.writeIyHigh = (r == 2'd3);
                    control.lastStep = 1'b1;
                end
                default: begin
                    control = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== stackGroupDecoder.sv ====
// Stack group decoder leaf for opcodes 000 1 1xx1, three steps through SP and PC.
`default_nettype none

module stackGroupDecoder (
    input  wire                          enable,
    input  wire  decodePkg::opIndex_t    opIndex,
    input  wire  decodePkg::stepIndex_t  step,
    output decodePkg::controlWord_t      control
);
    import decodePkg::*;

    logic [1:0] r;

    assign r = opIndex[2:1];

    always_comb begin
        control = '0;
        if (enable) begin
            case (step)
                stepIndex_t'(0): begin
                    control.decSp = 1'b1;
                    control.selectAdSp = 1'b1;
                    control.selectDtPcHigh = 1'b1;   // PC high byte first.
                    control.writeSlot = 3'b001;
                end
                stepIndex_t'(1): begin
                    control.decSp = 1'b1;
                    control.selectAdSp = 1'b1;
                    control.selectDtPcLow = 1'b1;
                    control.writeSlot = 3'b010;
                end
                stepIndex_t'(2): begin
                    control.writePcHigh = 1'b1;
                    control.writePcLow = 1'b1;
                    control.selectOldLow = 1'b1;
                    control.writeIxLow = (r == 2'd2);
                    control.writeIyLow = (r == 2'd3);
                    control.nop = (r == 2'd0);
                    control.lastStep = 1'b1;
                end
                default: begin
                    control = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== microDecoder.sv ====
// Root decoder node for 000x1xx1: splits on ITABLE[4] and merges the two group decoders.
`default_nettype none

module microDecoder (
    input  wire  decodePkg::opIndex_t    opIndex,
    input  wire  decodePkg::stepIndex_t  step,
    output decodePkg::controlWord_t      control
);
    import decodePkg::*;

    logic familyHit;
    controlWord_t transferCtl;
    controlWord_t stackCtl;

    assign familyHit = (opIndex[7:5] == 3'b000) && opIndex[3] && opIndex[0];

    transferGroupDecoder transferGroup (
        .enable  (familyHit && !opIndex[4]),   // 000 0 1xx1.
        .opIndex (opIndex),
        .step    (step),
        .control (transferCtl)
    );

    stackGroupDecoder stackGroup (
        .enable  (familyHit && opIndex[4]),    // 000 1 1xx1.
        .opIndex (opIndex),
        .step    (step),
        .control (stackCtl)
    );

    always_comb begin
        control = '0;
        if (familyHit) begin
            // Lines driven by both groups.
            control.readSlot    = transferCtl.readSlot | stackCtl.readSlot;
            control.writeSlot   = transferCtl.writeSlot | stackCtl.writeSlot;
            control.writeIxHigh = transferCtl.writeIxHigh | stackCtl.writeIxHigh;
            control.writeIyHigh = transferCtl.writeIyHigh | stackCtl.writeIyHigh;
            control.selectOld   = transferCtl.selectOld | stackCtl.selectOld;
            control.lastStep    = transferCtl.lastStep | stackCtl.lastStep;
            // Transfer only.
            control.selectAdt1 = transferCtl.selectAdt1;
            control.invertIn   = transferCtl.invertIn;
            control.writeL     = transferCtl.writeL;
            control.writeH     = transferCtl.writeH;
            // Stack only.
            control.writeIxLow     = stackCtl.writeIxLow;
            control.writeIyLow     = stackCtl.writeIyLow;
            control.decSp          = stackCtl.decSp;
            control.selectAdSp     = stackCtl.selectAdSp;
            control.selectDtPcHigh = stackCtl.selectDtPcHigh;
            control.selectDtPcLow  = stackCtl.selectDtPcLow;
            control.writePcHigh    = stackCtl.writePcHigh;
            control.writePcLow     = stackCtl.writePcLow;
            control.selectOldLow   = stackCtl.selectOldLow;
            control.nop            = stackCtl.nop;
        end else begin
            control.nop = 1'b1;         // Single-step no-operation.
            control.lastStep = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== opcodeQueue.sv ====
// Opcode FIFO, stage 1: buffers credited opcode beats and returns a credit per retired opcode.
`default_nettype none

`include "decode_macros.svh"

module opcodeQueue (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  decodePkg::opBeat_t  inOp,
    input  wire                       pop,
    output decodePkg::opBeat_t        headOp,
    output logic                      inCredit
);
    import decodePkg::*;

    localparam int PtrWidth   = $clog2(`QUEUE_DEPTH);
    localparam int CountWidth = $clog2(`QUEUE_DEPTH + 1);
    localparam logic [PtrWidth-1:0]   LastSlot  = PtrWidth'(`QUEUE_DEPTH - 1);
    localparam logic [CountWidth-1:0] FullCount = CountWidth'(`QUEUE_DEPTH);

    opIndex_t queueMem [`QUEUE_DEPTH];
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic [CountWidth-1:0] count;

    always_ff @(posedge clk) begin
        if (inOp.valid) begin
            queueMem[wrPtr] <= inOp.opIndex;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            inCredit <= 1'b0;
        end else begin
            if (inOp.valid) begin
                wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
            end
            case ({inOp.valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            inCredit <= pop;    // One credit per retired opcode.
        end
    end

    assign headOp.valid   = (count != '0);
    assign headOp.opIndex = queueMem[rdPtr];

    // Producer must hold a credit, so a full queue never sees a write.
    noWriteWhenFull: assert property (@(posedge clk) disable iff (reset)
        !(inOp.valid && count == FullCount))
        else $error("opcode written into a full queue");

    noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset)
        pop |-> count != '0)
        else $error("pop from an empty opcode queue");

endmodule

`default_nettype wire

// ==== stepSequencer.sv ====
// Step sequencer for stage 2 that walks the head opcode through its XPT steps via the decoder tree.
`default_nettype none

module stepSequencer (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  decodePkg::opBeat_t  headOp,
    input  wire                       accept,
    output logic                      pop,
    output decodePkg::microOp_t       stepOp
);
    import decodePkg::*;

    seqState_t state;
    stepIndex_t xpt;
    controlWord_t control;
    logic advance;

    microDecoder decoder (
        .opIndex (headOp.opIndex),
        .step    (xpt),
        .control (control)
    );

    assign advance = headOp.valid && accept;    // Step taken by issue stage.
    assign pop     = advance && control.lastStep;

    assign stepOp = '{
        valid:   headOp.valid,
        opIndex: headOp.opIndex,
        step:    xpt,
        control: control
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            xpt <= '0;
        end else if (advance) begin
            if (control.lastStep) begin
                state <= idle;
                xpt <= '0;
            end else begin
                state <= stepping;
                xpt <= xpt + 1'b1;
            end
        end
    end

    // The longest group has three steps.
    xptInRange: assert property (@(posedge clk) disable iff (reset)
        xpt <= stepIndex_t'(2))
        else $error("XPT passed 2 for opcode %h", headOp.opIndex);

    // The queue holds the opcode until its last step has left.
    headHeldWhileStepping: assert property (@(posedge clk) disable iff (reset)
        state == stepping |-> headOp.valid)
        else $error("head opcode lost in the middle of its steps");

endmodule

`default_nettype wire

// ==== issueStage.sv ====
// Issue stage for stage 3 that registers accepted micro-ops and tracks downstream credits.
`default_nettype none

`include "decode_macros.svh"

module issueStage (
    input  wire                        clk,
    input  wire                        reset,
    input  wire  decodePkg::microOp_t  stepOp,
    input  wire                        outCredit,
    output logic                       accept,
    output decodePkg::microOp_t        outOp
);
    localparam int CreditWidth = $clog2(`OUT_CREDITS + 1);
    localparam logic [CreditWidth-1:0] MaxCredits = CreditWidth'(`OUT_CREDITS);

    logic [CreditWidth-1:0] creditCount;
    logic send;

    assign accept = (creditCount != '0);
    assign send   = stepOp.valid && accept;

    always_ff @(posedge clk) begin
        if (send) begin
            outOp.opIndex <= stepOp.opIndex;
            outOp.step <= stepOp.step;
            outOp.control <= stepOp.control;
        end
        if (reset) begin
            outOp.valid <= 1'b0;
            creditCount <= MaxCredits;
        end else begin
            outOp.valid <= send;
            case ({send, outCredit})
                2'b10: creditCount <= creditCount - 1'b1;
                2'b01: creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;   // Spend and return cancel.
            endcase
        end
    end

    // The consumer returns no more credits than it was given.
    creditBounded: assert property (@(posedge clk) disable iff (reset)
        creditCount <= MaxCredits)
        else $error("downstream credit count above %0d", `OUT_CREDITS);

endmodule

`default_nettype wire

// ==== decodePipeTop.sv ====
// Micro-operation decode pipeline top: opcode queue, step sequencer and issue stage.
`default_nettype none

module decodePipeTop (
    input  wire                       clk,
    input  wire                       reset,
    input  wire  decodePkg::opBeat_t  inOp,
    output wire                       inCredit,
    output wire  decodePkg::microOp_t outOp,
    input  wire                       outCredit
);
    import decodePkg::*;

    opBeat_t headOp;
    microOp_t stepOp;
    logic pop;
    logic accept;

    opcodeQueue queue (
        .clk      (clk),
        .reset    (reset),
        .inOp     (inOp),
        .pop      (pop),
        .headOp   (headOp),
        .inCredit (inCredit)
    );

    stepSequencer sequencer (
        .clk    (clk),
        .reset  (reset),
        .headOp (headOp),
        .accept (accept),
        .pop    (pop),
        .stepOp (stepOp)
    );

    issueStage issue (
        .clk       (clk),
        .reset     (reset),
        .stepOp    (stepOp),
        .outCredit (outCredit),
        .accept    (accept),
        .outOp     (outOp)
    );

endmodule

`default_nettype wire

// ==== decodeChecker.sv ====
// Decode pipeline scoreboard: compares issued micro-ops and credit traffic with the expected ones.
`default_nettype none

`include "decode_macros.svh"

module decodeChecker (
    input  wire                        clk,
    input  wire                        reset,
    input  wire  decodePkg::opBeat_t   inOp,
    input  wire                        inCredit,
    input  wire  decodePkg::microOp_t  outOp,
    input  wire                        outCredit,
    output int                         testsDone,
    output int                         failCount,
    output int                         errorCount,
    output int                         creditsBack
);
    import decodePkg::*;

    localparam int BeatBits = $bits(microOp_t) - 1;    // Beat without its valid bit.

    string nameQ [$];
    opIndex_t opQ [$];
    int stepsQ [$];
    controlWord_t wordQ [$];

    int doneCnt = 0;
    int failCnt = 0;
    int errCnt = 0;
    int backCnt = 0;
    int beatsIn = 0;
    int beatsOut = 0;
    int creditsGiven = 0;
    int retired = 0;        // LastStep micro-ops seen.
    int stepNow = 0;
    logic wasReset = 1'b0;
    logic testBad = 1'b0;
    logic [BeatBits-1:0] expBeat;
    logic [BeatBits-1:0] actBeat;
    logic [BeatBits-1:0] badExp;
    logic [BeatBits-1:0] badAct;

    assign testsDone = doneCnt;
    assign failCount = failCnt;
    assign errorCount = errCnt;
    assign creditsBack = backCnt;

    task automatic expectTest(input string name, input opIndex_t op, input int steps,
                              input controlWord_t w0, input controlWord_t w1,
                              input controlWord_t w2);
        nameQ.push_back(name);
        opQ.push_back(op);
        stepsQ.push_back(steps);
        wordQ.push_back(w0);
        if (steps > 1) wordQ.push_back(w1);
        if (steps > 2) wordQ.push_back(w2);
    endtask

    task automatic reportFault(input string what);
        errCnt++;
        $display("%s", what);
    endtask

    task automatic finishTest();
        if (testBad) begin
            failCnt++;
            $display("ERR %s expected %h actual %h", nameQ[0], badExp, badAct);
        end else begin
            $display("PASS %s", nameQ[0]);
        end
        void'(nameQ.pop_front());
        void'(opQ.pop_front());
        void'(stepsQ.pop_front());
        stepNow = 0;
        testBad = 1'b0;
        doneCnt++;
    endtask

    task automatic checkMicroOp();
        beatsOut++;
        if (beatsOut > `OUT_CREDITS + creditsGiven)
            reportFault("More micro-ops issued than downstream credits given");
        if (nameQ.size() == 0) begin
            reportFault("Micro-op issued with no opcode pending");
            return;
        end
        expBeat = {opQ[0], stepIndex_t'(stepNow), wordQ.pop_front()};
        actBeat = {outOp.opIndex, outOp.step, outOp.control};
        if (expBeat != actBeat && !testBad) begin
            testBad = 1'b1;     // Keep the first mismatch of the test.
            badExp = expBeat;
            badAct = actBeat;
        end
        if (outOp.control.lastStep) retired++;
        stepNow++;
        if (stepNow == stepsQ[0]) finishTest();
    endtask

    always @(posedge clk) begin
        if (wasReset && (outOp.valid || inCredit))
            reportFault("Micro-op or upstream credit seen during or right after reset");
        wasReset = reset;
        if (!reset) begin
            if (inOp.valid) beatsIn++;
            if (outCredit) creditsGiven++;
            if (outOp.valid) checkMicroOp();
            if (inCredit) begin
                backCnt++;
                if (backCnt > retired)
                    reportFault("Upstream credit returned before the opcode's last step");
            end
            if (beatsIn - backCnt > `QUEUE_DEPTH)
                reportFault("More opcodes outstanding than the queue depth");
        end
    end

endmodule

`default_nettype wire

// ==== decodePipeTb.sv ====
// Decode pipeline testbench with clock, reset, opcode table, random credit consumer and watchdog.
`default_nettype none

`include "decode_macros.svh"

module decodePipeTb;
    import decodePkg::*;

    localparam int NumTests = 12;

    logic clk = 1'b0;
    logic reset;
    opBeat_t inOp;
    logic inCredit;
    microOp_t outOp;
    logic outCredit = 1'b0;

    int testsDone;
    int failCount;
    int errorCount;
    int creditsBack;
    int creditsReturned = 0;
    int owedCredits = 0;
    int pendingCredits;
    int sentCount;
    int nextTest;
    int creditErrors = 0;

    // **************************************************
    // Test table
    // **************************************************

    string testName [NumTests] = '{"xfer_09", "xfer_0b", "xfer_0d", "xfer_0f",
        "stack_19", "stack_1b", "stack_1d", "stack_1f", "nop_00", "nop_0a", "nop_29", "nop_ff"};
    opIndex_t testOp [NumTests] = '{8'h09, 8'h0B, 8'h0D, 8'h0F,
        8'h19, 8'h1B, 8'h1D, 8'h1F, 8'h00, 8'h0A, 8'h29, 8'hFF};
    int testSteps [NumTests] = '{2, 2, 2, 2, 3, 3, 3, 3, 1, 1, 1, 1};
    controlWord_t testWord [NumTests][3];

    function automatic controlWord_t expectedControl(input opIndex_t op, input int step);
        controlWord_t w;
        int r;
        w = '0;
        r = int'(op[2:1]);
        if ((op & 8'hE9) != 8'h09) begin    // Outside 000x1xx1.
            w.nop = 1'b1;
            w.lastStep = 1'b1;
        end else if (!op[4]) begin
            if (step == 0) begin
                w.selectOld = 1'b1;
                w.invertIn = (r == 3);
                if (r < 3) w.readSlot = (r == 0) ? 3'b001 : (r == 1) ? 3'b010 : 3'b100;
            end else begin
                if (r < 3) w.writeSlot = (r == 0) ? 3'b001 : (r == 1) ? 3'b010 : 3'b100;
                w.writeL = (r % 2 == 0);
                w.writeH = (r % 2 == 1);
                w.writeIxHigh = (r == 2);
                w.writeIyHigh = (r == 3);
                w.lastStep = 1'b1;
            end
        end else if (step < 2) begin        // Stack pushes of PC.
            w.decSp = 1'b1;
            w.selectAdSp = 1'b1;
            w.selectDtPcHigh = (step == 0);
            w.selectDtPcLow = (step == 1);
            w.writeSlot = (step == 0) ? 3'b001 : 3'b010;
        end else begin
            w.writePcHigh = 1'b1;
            w.writePcLow = 1'b1;
            w.selectOldLow = 1'b1;
            w.writeIxLow = (r == 2);
            w.writeIyLow = (r == 3);
            w.nop = (r == 0);
            w.lastStep = 1'b1;
        end
        return w;
    endfunction

    decodePipeTop uut (
        .clk       (clk),
        .reset     (reset),
        .inOp      (inOp),
        .inCredit  (inCredit),
        .outOp     (outOp),
        .outCredit (outCredit)
    );

    decodeChecker scoreboard (
        .clk         (clk),
        .reset       (reset),
        .inOp        (inOp),
        .inCredit    (inCredit),
        .outOp       (outOp),
        .outCredit   (outCredit),
        .testsDone   (testsDone),
        .failCount   (failCount),
        .errorCount  (errorCount),
        .creditsBack (creditsBack)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (inCredit) creditsReturned <= creditsReturned + 1;
    end

    // Consumer returns one credit per consumed micro-op after a random delay.
    always @(posedge clk) begin
        pendingCredits = reset ? 0 : owedCredits + int'(outOp.valid);
        outCredit <= 1'b0;
        if (pendingCredits > 0 && $urandom % 3 == 0) begin
            outCredit <= 1'b1;
            pendingCredits--;
        end
        owedCredits <= pendingCredits;
    end

    initial begin
        void'($urandom(32'h58be));
        reset = 1'b1;
        inOp = '0;
        for (int t = 0; t < NumTests; t++) begin
            for (int s = 0; s < 3; s++) begin
                testWord[t][s] = (s < testSteps[t]) ? expectedControl(testOp[t], s) : '0;
            end
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        sentCount = 0;
        nextTest = 0;
        while (nextTest < NumTests) begin
            @(posedge clk);
            if (sentCount - creditsReturned < `QUEUE_DEPTH) begin   // Holds a credit.
                scoreboard.expectTest(testName[nextTest], testOp[nextTest], testSteps[nextTest],
                    testWord[nextTest][0], testWord[nextTest][1], testWord[nextTest][2]);
                inOp <= '{valid: 1'b1, opIndex: testOp[nextTest]};
                sentCount++;
                nextTest++;
            end else begin
                inOp <= '0;
            end
        end
        @(posedge clk);
        inOp <= '0;
        while (testsDone < NumTests) @(posedge clk);
        repeat (4) @(posedge clk);
        if (creditsBack != NumTests) begin
            creditErrors++;
            $display("Upstream credits returned %0d for %0d opcodes", creditsBack, NumTests);
        end
        $display("Summary: %0d tests done, %0d failed, %0d other errors", testsDone, failCount,
            errorCount + creditErrors);
        if (failCount == 0 && errorCount == 0 && creditErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per table entry after reset.
    initial begin
        repeat (8 + NumTests * 40) @(posedge clk);
        $display("Timeout: micro-ops still missing after %0d cycles", NumTests * 40);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
decodePkg.sv
transferGroupDecoder.sv
stackGroupDecoder.sv
microDecoder.sv
opcodeQueue.sv
stepSequencer.sv
issueStage.sv
decodePipeTop.sv
decodeChecker.sv
decodePipeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the decode pipeline testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module decodePipeTb -f build.f

simOutput="$(./obj_dir/VdecodePipeTb)"
echo "$simOutput"

# Fails the script when the pass line is missing.
grep -qx 'All tests passed!' <<< "$simOutput"
